// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tbMips
FILELIST  := mipsPipeline.f
OBJDIR    := obj_dir
LOG       := sim.log
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

$(SIM): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "TEST FAILED: no result"; exit 1; }
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: alu.sv
// execute-stage ALU
//   add, sub, and, or, signed set-less-than
//   zero flag for beq
module alu
    import mipsPkg::*;
(
    input  aluOpT op,
    input  wordT  a,
    input  wordT  b,
    output wordT  result,
    output logic  zero
);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            // two's complement compare
            aluSlt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: ctrlUnit.sv
// decode-stage control
//   opcode to datapath control levels
//   R-type function code to ALU operation
module ctrlUnit
    import mipsPkg::*;
(
    input  opcodeT opcode,
    input  functT  funct,
    output logic   regWrite,
    output logic   memRead,
    output logic   memWrite,
    output logic   memToReg,
    output logic   aluSrcImm,
    output logic   regDstRd,
    output logic   branch,
    output logic   jump,
    output logic   halt,
    output aluOpT  aluOp
);

    always_comb begin
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        aluSrcImm = 1'b0;
        regDstRd  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        halt      = 1'b0;
        aluOp     = aluAdd;

        case (opcode)
            opRType: begin
                regWrite = 1'b1;
                regDstRd = 1'b1;
                case (funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr:  aluOp = aluOr;
                    fnSlt: aluOp = aluSlt;
                    // unsupported function code behaves as a bubble
                    default: begin
                        regWrite = 1'b0;
                        regDstRd = 1'b0;
                    end
                endcase
            end
            opAddi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            // address is rs + offset for both memory ops
            opLw: begin
                regWrite  = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opSw: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            // equality comes from the zero flag of rs - rt
            opBeq: begin
                branch = 1'b1;
                aluOp  = aluSub;
            end
            opJ:    jump = 1'b1;
            opHalt: halt = 1'b1;
            // unknown opcode, every control stays low
            default: ;
        endcase
    end

endmodule

// File: hazardUnit.sv
// pipeline hazard handling
//   operand forwarding selects for the execute stage
//   one-cycle load-use stall
//   flush on a taken branch or jump
module hazardUnit
    import mipsPkg::*;
(
    input  regAddrT idRs,
    input  regAddrT idRt,
    input  regAddrT exRs,
    input  regAddrT exRt,
    input  logic    exMemRead,
    input  regAddrT memRd,
    input  logic    memRegWrite,
    input  regAddrT wbRd,
    input  logic    wbRegWrite,
    input  logic    takeBranch,
    output fwdSelT  fwdA,
    output fwdSelT  fwdB,
    output logic    stall,
    output logic    flush
);

    // the younger producer in EX/MEM wins over MEM/WB
    function automatic fwdSelT pickSrc(
        input regAddrT src,
        input regAddrT memDst,
        input logic    memWr,
        input regAddrT wbDst,
        input logic    wbWr
    );
        if (memWr && memDst != '0 && memDst == src) begin
            return fwdExMem;
        end
        if (wbWr && wbDst != '0 && wbDst == src) begin
            return fwdMemWb;
        end
        return fwdReg;
    endfunction

    assign fwdA = pickSrc(exRs, memRd, memRegWrite, wbRd, wbRegWrite);
    assign fwdB = pickSrc(exRt, memRd, memRegWrite, wbRd, wbRegWrite);

    // branch or jump resolved in MEM squashes IF, ID and EX
    assign flush = takeBranch;

    // load data is only ready from MEM/WB, so the consumer waits a cycle
    // no point holding an instruction that is about to be squashed
    assign stall = exMemRead && !flush && (exRt == idRs || exRt == idRt);

endmodule

// File: mipsPipeline.f
mipsPkg.sv
wordMem.sv
regFile.sv
ctrlUnit.sv
hazardUnit.sv
alu.sv
mipsPipeline.sv
tbMips.sv

// File: mipsPipeline.sv
// top level of the five-stage MIPS-subset pipeline
//   PC with halt freeze, IF/ID, ID/EX, EX/MEM and MEM/WB registers
//   branch and jump target arithmetic, forwarding muxes
//   program load port into instruction memory
//   retire port showing each register write
module mipsPipeline
    import mipsPkg::*;
#(
    parameter int ImemDepth = 256,
    parameter int DmemDepth = 256
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    progWr,
    input  wordT    progAddr,
    input  wordT    progData,
    output logic    fin,
    output logic    wbValid,
    output regAddrT wbAddr,
    output wordT    wbData
);

    // fetch
    wordT pc;
    wordT pcPlus4;
    wordT imemAddr;
    wordT fetchInstr;
    logic halted;

    // IF/ID
    logic ifIdValid;
    wordT ifIdInstr;
    wordT ifIdPcPlus4;

    // decode
    regAddrT idRs;
    regAddrT idRt;
    regAddrT idRd;
    wordT    idImm;
    wordT    idTarget;
    wordT    rdData1;
    wordT    rdData2;
    logic    idHalt;
    logic    idKill;
    logic    ctrlRegWrite;
    logic    ctrlMemRead;
    logic    ctrlMemWrite;
    logic    ctrlMemToReg;
    logic    ctrlAluSrcImm;
    logic    ctrlRegDstRd;
    logic    ctrlBranch;
    logic    ctrlJump;
    logic    ctrlHalt;
    aluOpT   ctrlAluOp;
    logic [8:0] idCtrl;

    // ID/EX
    logic [8:0] idExCtrl;
    aluOpT   idExAluOp;
    logic    idExRegWrite;
    logic    idExMemRead;
    logic    idExMemWrite;
    logic    idExMemToReg;
    logic    idExAluSrcImm;
    logic    idExRegDstRd;
    logic    idExBranch;
    logic    idExJump;
    logic    idExHalt;
    wordT    idExRsData;
    wordT    idExRtData;
    wordT    idExImm;
    wordT    idExTarget;
    regAddrT idExRs;
    regAddrT idExRt;
    regAddrT idExRd;

    // execute
    fwdSelT  fwdA;
    fwdSelT  fwdB;
    wordT    exOpA;
    wordT    exRtVal;
    wordT    exOpB;
    wordT    aluResult;
    logic    aluZero;
    regAddrT exDest;

    // EX/MEM
    logic    exMemRegWrite;
    logic    exMemMemWrite;
    logic    exMemMemToReg;
    logic    exMemBranch;
    logic    exMemJump;
    logic    exMemHalt;
    logic    exMemZero;
    wordT    exMemAluResult;
    wordT    exMemStoreData;
    wordT    exMemTarget;
    regAddrT exMemRd;

    // memory
    wordT memData;
    logic takeBranch;

    // MEM/WB
    logic    memWbRegWrite;
    logic    memWbMemToReg;
    wordT    memWbAluResult;
    wordT    memWbMemData;
    regAddrT memWbRd;

    // hazards
    logic stall;
    logic flush;

    function automatic wordT fwdMux(
        input fwdSelT sel,
        input wordT   regVal,
        input wordT   exMemVal,
        input wordT   memWbVal
    );
        case (sel)
            fwdExMem: return exMemVal;
            fwdMemWb: return memWbVal;
            default:  return regVal;
        endcase
    endfunction

    // fetch stage
    assign pcPlus4 = pc + 32'd4;

    // the load port takes over the address while it writes
    assign imemAddr = progWr ? progAddr : pc;

    wordMem #(.Depth(ImemDepth)) imem_i (
        .clk    (clk),
        .wr     (progWr),
        .addr   (imemAddr),
        .wrData (progData),
        .rdData (fetchInstr)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (flush) begin
            // a halt on the squashed path must not freeze fetch
            pc     <= exMemTarget;
            halted <= 1'b0;
        end else begin
            if (!stall && !halted && !idHalt) begin
                pc <= pcPlus4;
            end
            if (idHalt) begin
                halted <= 1'b1;
            end
        end
    end

    // IF/ID takes bubbles once halt has been seen in decode
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifIdValid <= 1'b0;
        end else if (flush || (!stall && (halted || idHalt))) begin
            ifIdValid <= 1'b0;
        end else if (!stall) begin
            ifIdValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifIdInstr   <= fetchInstr;
            ifIdPcPlus4 <= pcPlus4;
        end
    end

    // decode stage
    assign idRs  = ifIdInstr[25:21];
    assign idRt  = ifIdInstr[20:16];
    assign idRd  = ifIdInstr[15:11];
    assign idImm = signExtImm(ifIdInstr[15:0]);

    // only one of the two targets is ever needed downstream
    assign idTarget = ctrlJump ? {ifIdPcPlus4[31:28], ifIdInstr[25:0], 2'b00}
                               : ifIdPcPlus4 + (idImm << 2);

    assign idHalt = ifIdValid && ctrlHalt;
    assign idKill = flush || stall || !ifIdValid;

    ctrlUnit ctrlUnit_i (
        .opcode    (opcodeT'(ifIdInstr[31:26])),
        .funct     (functT'(ifIdInstr[5:0])),
        .regWrite  (ctrlRegWrite),
        .memRead   (ctrlMemRead),
        .memWrite  (ctrlMemWrite),
        .memToReg  (ctrlMemToReg),
        .aluSrcImm (ctrlAluSrcImm),
        .regDstRd  (ctrlRegDstRd),
        .branch    (ctrlBranch),
        .jump      (ctrlJump),
        .halt      (ctrlHalt),
        .aluOp     (ctrlAluOp)
    );

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .wr      (memWbRegWrite),
        .rdAddr1 (idRs),
        .rdAddr2 (idRt),
        .wrAddr  (memWbRd),
        .wrData  (wbData),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    assign idCtrl = {ctrlRegWrite, ctrlMemRead, ctrlMemWrite, ctrlMemToReg, ctrlAluSrcImm,
                     ctrlRegDstRd, ctrlBranch, ctrlJump, ctrlHalt};

    // ID/EX
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idExCtrl  <= '0;
            idExAluOp <= aluAdd;
        end else if (idKill) begin
            idExCtrl  <= '0;
            idExAluOp <= aluAdd;
        end else begin
            idExCtrl  <= idCtrl;
            idExAluOp <= ctrlAluOp;
        end
    end

    assign {idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg, idExAluSrcImm,
            idExRegDstRd, idExBranch, idExJump, idExHalt} = idExCtrl;

    always_ff @(posedge clk) begin
        idExRsData <= rdData1;
        idExRtData <= rdData2;
        idExImm    <= idImm;
        idExTarget <= idTarget;
        idExRs     <= idRs;
        idExRt     <= idRt;
        idExRd     <= idRd;
    end

    // execute stage
    hazardUnit hazardUnit_i (
        .idRs        (idRs),
        .idRt        (idRt),
        .exRs        (idExRs),
        .exRt        (idExRt),
        .exMemRead   (idExMemRead),
        .memRd       (exMemRd),
        .memRegWrite (exMemRegWrite),
        .wbRd        (memWbRd),
        .wbRegWrite  (memWbRegWrite),
        .takeBranch  (takeBranch),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .stall       (stall),
        .flush       (flush)
    );

    assign exOpA   = fwdMux(fwdA, idExRsData, exMemAluResult, wbData);
    // forwarded rt also feeds the store data
    assign exRtVal = fwdMux(fwdB, idExRtData, exMemAluResult, wbData);
    assign exOpB   = idExAluSrcImm ? idExImm : exRtVal;
    assign exDest  = idExRegDstRd ? idExRd : idExRt;

    alu alu_i (
        .op     (idExAluOp),
        .a      (exOpA),
        .b      (exOpB),
        .result (aluResult),
        .zero   (aluZero)
    );

    // EX/MEM
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMemRegWrite <= 1'b0;
            exMemMemWrite <= 1'b0;
            exMemMemToReg <= 1'b0;
            exMemBranch   <= 1'b0;
            exMemJump     <= 1'b0;
            exMemHalt     <= 1'b0;
        end else begin
            // a flush turns the instruction leaving execute into a bubble
            exMemRegWrite <= idExRegWrite && !flush;
            exMemMemWrite <= idExMemWrite && !flush;
            exMemMemToReg <= idExMemToReg && !flush;
            exMemBranch   <= idExBranch && !flush;
            exMemJump     <= idExJump && !flush;
            exMemHalt     <= idExHalt && !flush;
        end
    end

    always_ff @(posedge clk) begin
        exMemZero      <= aluZero;
        exMemAluResult <= aluResult;
        exMemStoreData <= exRtVal;
        exMemTarget    <= idExTarget;
        exMemRd        <= exDest;
    end

    // memory stage
    wordMem #(.Depth(DmemDepth)) dmem_i (
        .clk    (clk),
        .wr     (exMemMemWrite),
        .addr   (exMemAluResult),
        .wrData (exMemStoreData),
        .rdData (memData)
    );

    assign takeBranch = exMemJump || (exMemBranch && exMemZero);

    // MEM/WB
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWbRegWrite <= 1'b0;
            memWbMemToReg <= 1'b0;
        end else begin
            memWbRegWrite <= exMemRegWrite;
            memWbMemToReg <= exMemMemToReg;
        end
    end

    always_ff @(posedge clk) begin
        memWbAluResult <= exMemAluResult;
        memWbMemData   <= memData;
        memWbRd        <= exMemRd;
    end

    // sticky flag set as halt enters write-back
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fin <= 1'b0;
        end else if (exMemHalt) begin
            fin <= 1'b1;
        end
    end

    // write-back stage
    assign wbData  = memWbMemToReg ? memWbMemData : memWbAluResult;
    assign wbAddr  = memWbRd;
    assign wbValid = memWbRegWrite && (memWbRd != '0);

endmodule

// File: mipsPkg.sv
// shared definitions for the MIPS pipeline
//   word and register-number types
//   opcode and R-type function encodings, halt included
//   ALU operation and forwarding select encodings
//   immediate sign extension
package mipsPkg;

    // data word and byte address
    typedef logic [31:0] wordT;

    typedef logic [4:0] regAddrT;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opRType = 6'd0,
        opJ     = 6'd2,
        opBeq   = 6'd4,
        opAddi  = 6'd8,
        opLw    = 6'd35,
        opSw    = 6'd43,
        // stops fetch and raises fin once it retires
        opHalt  = 6'd63
    } opcodeT;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        fnAdd = 6'd32,
        fnSub = 6'd34,
        fnAnd = 6'd36,
        fnOr  = 6'd37,
        fnSlt = 6'd42
    } functT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    // execute operand source
    typedef enum logic [1:0] {
        fwdReg   = 2'd0,
        fwdExMem = 2'd1,
        fwdMemWb = 2'd2
    } fwdSelT;

    // 16-bit immediate to a full word
    function automatic wordT signExtImm(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

endpackage

// File: regFile.sv
// 32-entry register file
//   two combinational read ports, one write port
//   register 0 reads as zero
//   write data shows through to a read of the same register
module regFile
    import mipsPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    wr,
    input  regAddrT rdAddr1,
    input  regAddrT rdAddr2,
    input  regAddrT wrAddr,
    input  wordT    wrData,
    output wordT    rdData1,
    output wordT    rdData2
);

    wordT regs [32];
    logic wrLive;

    // writes to register 0 are dropped
    assign wrLive = wr && (wrAddr != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // decode reads in the same cycle as write-back, so bypass
    assign rdData1 = (wrLive && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
    assign rdData2 = (wrLive && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

endmodule

// File: tbMips.sv
// testbench for the MIPS pipeline
//   clock, reset and program load through the load port
//   program generators and an in-order ISA reference model
//   retire port checks against the model's write queue
module tbMips
    import mipsPkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam regAddrT MarkerReg = 5'd30;
    localparam int ResetCycles = 16;
    localparam int RunLimit = 300;
    localparam int HoldCycles = 20;

    logic    clk;
    logic    rstN;
    logic    progWr;
    wordT    progAddr;
    wordT    progData;
    logic    fin;
    logic    wbValid;
    regAddrT wbAddr;
    wordT    wbData;

    wordT prog [16];
    int   progLen;
    logic [31:0] rngState = 32'h9725fbca;

    // model state and the expected retire sequence
    wordT    modelRegs [32];
    wordT    modelMem [wordT];
    regAddrT expAddr [$];
    wordT    expData [$];

    mipsPipeline mipsPipeline_i (
        .clk      (clk),
        .rstN     (rstN),
        .progWr   (progWr),
        .progAddr (progAddr),
        .progData (progData),
        .fin      (fin),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // instruction encoders
    function automatic wordT encR(functT fn, regAddrT rd, regAddrT rs, regAddrT rt);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT encI(opcodeT op, regAddrT rt, regAddrT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encJ(logic [25:0] idx);
        return {opJ, idx};
    endfunction

    function automatic wordT encHalt();
        return {opHalt, 26'd0};
    endfunction

    // register write that must never retire
    function automatic wordT markerInstr();
        return encI(opAddi, MarkerReg, 5'd0, 16'h7bad);
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string sig, input wordT got, input wordT exp);
        abortRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", sig, got, exp));
    endtask

    task automatic modelWrite(input regAddrT dst, input wordT val);
        if (dst != 5'd0) begin
            modelRegs[dst] = val;
            expAddr.push_back(dst);
            expData.push_back(val);
        end
    endtask

    // executes prog in order until halt and queues every register write
    task automatic runModel();
        wordT    pc;
        wordT    pcPlus4;
        wordT    pcNext;
        wordT    ins;
        wordT    a;
        wordT    b;
        wordT    imm;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        int      steps;
        logic    done;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        pc = '0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 64) begin
            ins = prog[pc[5:2]];
            rs = ins[25:21];
            rt = ins[20:16];
            rd = ins[15:11];
            imm = {{16{ins[15]}}, ins[15:0]};
            a = modelRegs[rs];
            b = modelRegs[rt];
            pcPlus4 = pc + 32'd4;
            pcNext = pcPlus4;
            case (ins[31:26])
                opRType: begin
                    case (ins[5:0])
                        fnAdd: modelWrite(rd, a + b);
                        fnSub: modelWrite(rd, a - b);
                        fnAnd: modelWrite(rd, a & b);
                        fnOr:  modelWrite(rd, a | b);
                        fnSlt: modelWrite(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                opAddi: modelWrite(rt, a + imm);
                opLw:   modelWrite(rt, modelMem[a + imm]);
                opSw:   modelMem[a + imm] = b;
                opBeq: begin
                    if (a == b) begin
                        pcNext = pcPlus4 + (imm << 2);
                    end
                end
                opJ:    pcNext = {pcPlus4[31:28], ins[25:0], 2'b00};
                opHalt: done = 1'b1;
                default: ;
            endcase
            pc = pcNext;
            steps++;
        end
    endtask

    // random ALU ops that mostly read the last two results
    task automatic aluChainProgram();
        logic [31:0] r;
        logic [31:0] immRnd;
        regAddrT     prev1;
        regAddrT     prev2;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     dst;
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int i = 0; i < 14; i++) begin
            r = nextRand();
            immRnd = nextRand();
            rs = (r[1:0] != 2'b00) ? prev1 : {2'b00, r[4:2]};
            rt = (r[6:5] != 2'b00) ? prev2 : {2'b00, r[9:7]};
            // r0 shows up now and then as a destination
            dst = {2'b00, r[12:10]};
            if (i < 3 || r[15:13] > 3'd4) begin
                prog[i] = encI(opAddi, dst, rs, immRnd[15:0]);
            end else begin
                case (r[15:13])
                    3'd0:    prog[i] = encR(fnAdd, dst, rs, rt);
                    3'd1:    prog[i] = encR(fnSub, dst, rs, rt);
                    3'd2:    prog[i] = encR(fnAnd, dst, rs, rt);
                    3'd3:    prog[i] = encR(fnOr, dst, rs, rt);
                    default: prog[i] = encR(fnSlt, dst, rs, rt);
                endcase
            end
            prev2 = prev1;
            prev1 = dst;
        end
        prog[14] = encHalt();
        // fetched behind halt and never retired
        prog[15] = markerInstr();
        progLen = 16;
    endtask

    task automatic memoryProgram();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = nextRand();
        r2 = nextRand();
        prog[0]  = encI(opAddi, 5'd1, 5'd0, 16'h0040);
        prog[1]  = encI(opAddi, 5'd2, 5'd0, r1[15:0]);
        prog[2]  = encI(opSw, 5'd2, 5'd1, 16'd0);
        prog[3]  = encI(opAddi, 5'd3, 5'd0, r2[15:0]);
        prog[4]  = encI(opSw, 5'd3, 5'd1, 16'd4);
        prog[5]  = encI(opLw, 5'd4, 5'd1, 16'd0);
        // each load is consumed by the very next instruction
        prog[6]  = encR(fnAdd, 5'd5, 5'd4, 5'd3);
        prog[7]  = encI(opLw, 5'd6, 5'd1, 16'd4);
        prog[8]  = encR(fnSub, 5'd7, 5'd6, 5'd4);
        prog[9]  = encI(opSw, 5'd7, 5'd1, 16'd8);
        prog[10] = encI(opLw, 5'd8, 5'd1, 16'd8);
        prog[11] = encR(fnOr, 5'd9, 5'd8, 5'd8);
        prog[12] = encHalt();
        prog[13] = markerInstr();
        progLen = 14;
    endtask

    task automatic branchProgram();
        wordT marker;
        marker = markerInstr();
        prog[0]  = encI(opAddi, 5'd1, 5'd0, 16'd5);
        prog[1]  = encI(opAddi, 5'd2, 5'd0, 16'd5);
        // taken branch that lands on word 6
        prog[2]  = encI(opBeq, 5'd2, 5'd1, 16'd3);
        prog[3]  = marker;
        prog[4]  = marker;
        prog[5]  = marker;
        prog[6]  = encI(opAddi, 5'd3, 5'd0, 16'd7);
        // not taken since 5 differs from 7
        prog[7]  = encI(opBeq, 5'd3, 5'd1, 16'd3);
        prog[8]  = encI(opAddi, 5'd4, 5'd3, 16'd1);
        prog[9]  = encJ(26'd13);
        prog[10] = marker;
        prog[11] = marker;
        prog[12] = marker;
        prog[13] = encR(fnAdd, 5'd5, 5'd4, 5'd1);
        prog[14] = encHalt();
        prog[15] = marker;
        progLen = 16;
    endtask

    task automatic checkRetire();
        regAddrT eAddr;
        wordT    eData;
        assert (wbAddr != MarkerReg)
            else abortRun("an instruction from a flushed slot retired");
        assert (expAddr.size() != 0)
            else abortRun("a register write retired after the expected sequence ended");
        eAddr = expAddr.pop_front();
        eData = expData.pop_front();
        assert (wbAddr == eAddr) else reportMismatch("wbAddr", 32'(wbAddr), 32'(eAddr));
        assert (wbData == eData) else reportMismatch("wbData", wbData, eData);
    endtask

    // reset with program load and follow the retire port until fin
    task automatic runProgram(input string name);
        int cycles;
        int total;
        expAddr.delete();
        expData.delete();
        runModel();
        total = expAddr.size();
        @(negedge clk);
        rstN = 1'b0;
        for (int c = 0; c < ResetCycles; c++) begin
            progWr = (c < progLen);
            progAddr = c * 4;
            progData = prog[c];
            @(negedge clk);
        end
        progWr = 1'b0;
        rstN = 1'b1;

        // first write-back is four edges away
        assert (!fin && !wbValid) else abortRun("fin or wbValid high right after reset");
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            assert (!fin && !wbValid)
                else abortRun("fin or wbValid high before the first write-back");
        end

        cycles = 0;
        while (!fin && cycles < RunLimit) begin
            @(negedge clk);
            cycles++;
            if (wbValid) begin
                checkRetire();
            end
        end
        if (!fin) begin
            abortRun($sformatf("timeout waiting for fin in program %s", name));
        end
        assert (expAddr.size() == 0)
            else abortRun($sformatf("fin rose with %0d expected writes outstanding",
                                    expAddr.size()));

        for (int c = 0; c < HoldCycles; c++) begin
            @(negedge clk);
            assert (fin) else abortRun("fin dropped after halt retired");
            assert (!wbValid) else abortRun("a register write retired after halt");
        end
        $display("program %s: %0d writes retired", name, total);
    endtask

    initial begin
        rstN     = 1'b0;
        progWr   = 1'b0;
        progAddr = '0;
        progData = '0;
        aluChainProgram();
        runProgram("alu chain");
        memoryProgram();
        runProgram("store and load");
        branchProgram();
        runProgram("branch and jump");
        $display("Verification passed");
        $finish;
    end

endmodule

// File: wordMem.sv
// word-wide memory
//   combinational read, write on the rising clock edge
//   byte addressed, wraps at Depth words
module wordMem
    import mipsPkg::*;
#(
    parameter int Depth = 256
) (
    input  logic clk,
    input  logic wr,
    input  wordT addr,
    input  wordT wrData,
    output wordT rdData
);

    localparam int IdxW = $clog2(Depth);

    wordT mem [Depth];
    logic [IdxW-1:0] idx;

    // drop the byte offset, then wrap into the array
    assign idx = IdxW'((addr >> 2) % Depth);

    assign rdData = mem[idx];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[idx] <= wrData;
        end
    end

endmodule
